//--- Makefile
# Verilator build and run of the APB subsystem testbench

SIM  := obj_dir/Vtb_apb_subsys
SRCS := $(wildcard verilog/*.sv verilog/*.svh dv/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) tb.f
	verilator --binary --timing -Mdir obj_dir --top-module tb_apb_subsys -f tb.f

# The log decides pass or fail
run: $(SIM)
	-./$(SIM) > sim.log 2>&1
	@cat sim.log
	@grep -q "^Result: PASSED$$" sim.log || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- dv/tb_apb_subsys.sv
// Testbench for the APB subsystem: clock, reset, stimulus table, reference model, checks, watchdog
`timescale 1ns/100ps
`include "apb_sub_params.svh"

module tb_apb_subsys;

  import apb_sub_pkg::*;

  localparam int NUM_TAB  = 19;
  localparam int NUM_RAND = 48;
  localparam int NUM_ALL  = NUM_TAB + NUM_RAND;
  localparam int NUM_REGS = 1 << `APB_REG_IDX_W;
  // Reset plus a generous budget per command
  localparam int WATCHDOG_CYCLES = 8 + NUM_ALL * 40;

  typedef struct packed {
    apb_cmd_t cmd;
    apb_rsp_t exp;
  } stim_t;

  logic     pclk;
  logic     presetn;
  logic     cmd_req;
  logic     cmd_ack;
  apb_cmd_t cmd;
  logic     rsp_req;
  logic     rsp_ack;
  apb_rsp_t rsp_out;

  stim_t                  stim [NUM_ALL];
  int                     delay [NUM_ALL];
  logic [`APB_DATA_W-1:0] model_regs [`APB_NUM_CPL][NUM_REGS];
  apb_rsp_t               got_rsp;
  int                     n_stim;
  int                     rsp_count;
  integer                 seed;

  apb_subsys_top dut0 (
    .pclk    (pclk),
    .presetn (presetn),
    .cmd_req (cmd_req),
    .cmd_ack (cmd_ack),
    .cmd     (cmd),
    .rsp_req (rsp_req),
    .rsp_ack (rsp_ack),
    .rsp_out (rsp_out)
  );

  always #2 pclk = ~pclk;

  task automatic check_eq(input string name, input logic [31:0] got,
                          input logic [31:0] expected);
    if (got !== expected) begin
      $display("FAILED at time %0t: %s = %h, expected %h", $time, name, got, expected);
      $display("Result: FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // Region in bits 11..8, offset guard in 7..6, register index in 5..2
  function automatic logic [`APB_ADDR_W-1:0] make_addr(input logic [3:0] region,
                                                       input logic [1:0] guard,
                                                       input logic [3:0] idx);
    return {4'h0, region, guard, idx, 2'b00};
  endfunction

  // Mirror of both register banks
  task automatic model_access(input apb_cmd_t c, output apb_rsp_t r);
    logic [3:0] region;
    logic [1:0] guard;
    logic [3:0] idx;
    region  = c.addr[11:8];
    guard   = c.addr[7:6];
    idx     = c.addr[5:2];
    r.write = c.write;
    r.rdata = '0;
    r.err   = 1'b0;
    if (int'(region) >= `APB_NUM_CPL || guard != 2'b00) begin
      r.err = 1'b1;
    end else if (c.write) begin
      model_regs[region[0]][idx] = c.wdata;
    end else begin
      r.rdata = model_regs[region[0]][idx];
    end
  endtask

  // Table row with its expected response written out by hand
  task automatic add_entry(input int write, input int region, input int guard, input int idx,
                           input int wdata, input int exp_err, input int exp_rdata);
    apb_cmd_t c;
    apb_rsp_t e;
    apb_rsp_t m;
    c.write = 1'(write);
    c.addr  = make_addr(4'(region), 2'(guard), 4'(idx));
    c.wdata = wdata;
    e.write = 1'(write);
    e.rdata = exp_rdata;
    e.err   = 1'(exp_err);
    // Keeps the mirror in step for the random traffic later
    model_access(c, m);
    stim[n_stim].cmd = c;
    stim[n_stim].exp = e;
    n_stim++;
  endtask

  task automatic add_random();
    logic [31:0] r;
    logic [3:0]  region;
    logic [1:0]  guard;
    apb_cmd_t    c;
    apb_rsp_t    e;
    r = $random(seed);
    // Mostly the two banks, now and then an unmapped region or a bad offset
    region  = (r[3:1] == 3'd0) ? {1'b1, r[6:4]} : {3'b000, r[7]};
    guard   = (r[10:8] == 3'd0) ? r[12:11] : 2'b00;
    c.write = r[0];
    c.addr  = make_addr(region, guard, {1'b0, r[15:13]});
    c.wdata = $random(seed);
    model_access(c, e);
    stim[n_stim].cmd = c;
    stim[n_stim].exp = e;
    n_stim++;
  endtask

  task automatic build_stimulus();
    logic [31:0] r;
    for (int k = 0; k < `APB_NUM_CPL; k++) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        model_regs[k][i] = '0;
      end
    end
    // Reset values, even and odd indexes on both banks
    add_entry(0, 0, 0, 0, 0, 0, 0);
    add_entry(0, 0, 0, 1, 0, 0, 0);
    add_entry(0, 1, 0, 2, 0, 0, 0);
    add_entry(0, 1, 0, 3, 0, 0, 0);
    // Same index on both banks
    add_entry(1, 0, 0, 3, 32'ha5a5_0001, 0, 0);
    add_entry(1, 1, 0, 3, 32'h5a5a_0002, 0, 0);
    add_entry(0, 0, 0, 3, 0, 0, 32'ha5a5_0001);
    add_entry(0, 1, 0, 3, 0, 0, 32'h5a5a_0002);
    // Nonzero offset guard
    add_entry(1, 0, 1, 4, 32'hdead_beef, 1, 0);
    add_entry(0, 0, 0, 4, 0, 0, 0);
    add_entry(1, 0, 2, 3, 32'h0000_1234, 1, 0);
    add_entry(0, 0, 3, 3, 0, 1, 0);
    add_entry(0, 0, 0, 3, 0, 0, 32'ha5a5_0001);
    // Unmapped regions, then proof that nothing moved on either bank
    add_entry(1, 2, 0, 3, 32'hffff_ffff, 1, 0);
    add_entry(0, 15, 0, 0, 0, 1, 0);
    add_entry(0, 0, 0, 3, 0, 0, 32'ha5a5_0001);
    add_entry(0, 1, 0, 3, 0, 0, 32'h5a5a_0002);
    add_entry(1, 1, 0, 0, 32'h0000_00c3, 0, 0);
    add_entry(0, 1, 0, 0, 0, 0, 32'h0000_00c3);
    for (int i = 0; i < NUM_RAND; i++) begin
      add_random();
    end
    // Sink back-pressure, 0 to 7 cycles per response
    for (int i = 0; i < NUM_ALL; i++) begin
      r = $random(seed);
      delay[i] = int'(r[2:0]);
    end
  endtask

  // Entered and left on a falling edge
  task automatic send_cmd(input apb_cmd_t c);
    cmd     = c;
    cmd_req = 1'b1;
    @(negedge pclk);
    while (!cmd_ack) @(negedge pclk);
    cmd_req = 1'b0;
    while (cmd_ack) @(negedge pclk);
  endtask

  task automatic recv_rsp(input int wait_cycles, output apb_rsp_t r);
    while (!rsp_req) @(negedge pclk);
    r = rsp_out;
    repeat (wait_cycles) @(negedge pclk);
    check_eq("rsp_out.rdata held", rsp_out.rdata, r.rdata);
    rsp_ack = 1'b1;
    @(negedge pclk);
    while (rsp_req) @(negedge pclk);
    rsp_ack = 1'b0;
    @(negedge pclk);
  endtask

  initial begin
    pclk      = 1'b0;
    presetn   = 1'b0;
    cmd_req   = 1'b0;
    cmd       = '0;
    rsp_ack   = 1'b0;
    rsp_count = 0;
    n_stim    = 0;
    seed      = 32'hd3e9ea53;
    build_stimulus();
    repeat (8) @(posedge pclk);
    @(negedge pclk);
    presetn = 1'b1;
    @(negedge pclk);
    check_eq("cmd_ack", 32'(cmd_ack), 32'd0);
    check_eq("rsp_req", 32'(rsp_req), 32'd0);
    check_eq("psel", 32'(dut0.psel), 32'd0);
    check_eq("penable", 32'(dut0.bus.penable), 32'd0);
    fork
      begin
        for (int i = 0; i < NUM_ALL; i++) begin
          send_cmd(stim[i].cmd);
        end
      end
      begin
        for (int i = 0; i < NUM_ALL; i++) begin
          recv_rsp(delay[i], got_rsp);
          check_eq($sformatf("rsp_out.write[%0d]", i), 32'(got_rsp.write),
                   32'(stim[i].exp.write));
          check_eq($sformatf("rsp_out.rdata[%0d]", i), got_rsp.rdata, stim[i].exp.rdata);
          check_eq($sformatf("rsp_out.err[%0d]", i), 32'(got_rsp.err), 32'(stim[i].exp.err));
          rsp_count++;
        end
      end
    join
    // No stray response after the last one
    repeat (10) @(negedge pclk);
    check_eq("rsp_req after last", 32'(rsp_req), 32'd0);
    $display("Result: PASSED");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge pclk);
    $display("Watchdog expired after %0d cycles with %0d of %0d responses received",
             WATCHDOG_CYCLES, rsp_count, NUM_ALL);
    $display("Result: FAILED");
    $fatal(1, "Simulation timed out");
  end

endmodule

//--- tb.f
+incdir+verilog
verilog/apb_sub_pkg.sv
verilog/apb_cmd_stage.sv
verilog/apb_requester.sv
verilog/apb_completer_regs.sv
verilog/apb_rsp_stage.sv
verilog/apb_subsys_top.sv
dv/tb_apb_subsys.sv

//--- verilog/apb_cmd_stage.sv
// Command intake stage: four-phase req/ack port and one-entry holding register
`timescale 1ns/100ps
`include "apb_sub_params.svh"

module apb_cmd_stage (
  input  logic                  pclk,
  input  logic                  presetn,
  input  logic                  cmd_req,
  output logic                  cmd_ack,
  input  apb_sub_pkg::apb_cmd_t cmd,
  output logic                  cmd_valid,
  input  logic                  cmd_ready,
  output apb_sub_pkg::apb_cmd_t cmd_out
);

  logic full;
  logic capture;
  logic xfer;

  // New command only once the last handshake has returned to zero
  assign capture = cmd_req && !full && !cmd_ack;
  assign xfer    = cmd_valid && cmd_ready;

  assign cmd_valid = full;

  always_ff @(posedge pclk or negedge presetn) begin
    if (!presetn) begin
      full    <= 1'b0;
      cmd_ack <= 1'b0;
    end else begin
      if (capture) begin
        full    <= 1'b1;
        cmd_ack <= 1'b1;
      end else begin
        // Holding register drains into the requester
        if (xfer) begin
          full <= 1'b0;
        end
        // Source has seen ack and let go of req
        if (cmd_ack && !cmd_req) begin
          cmd_ack <= 1'b0;
        end
      end
    end
  end

  // Payload
  always_ff @(posedge pclk) begin
    if (capture) begin
      cmd_out <= cmd;
    end
  end

endmodule

//--- verilog/apb_completer_regs.sv
// APB completer: register bank, odd-index wait state and offset-guard slave error
`timescale 1ns/100ps
`include "apb_sub_params.svh"

module apb_completer_regs (
  input  logic                  pclk,
  input  logic                  presetn,
  input  logic                  psel,
  input  apb_sub_pkg::apb_bus_t bus,
  output apb_sub_pkg::apb_cpl_t cpl
);

  localparam int NUM_REGS = 1 << `APB_REG_IDX_W;

  logic [`APB_DATA_W-1:0]    regs [NUM_REGS];
  logic [`APB_REG_IDX_W-1:0] idx;
  logic                      guard_err;
  logic                      access;
  logic                      waited;
  logic                      done;

  assign idx       = bus.paddr[`APB_IDX_LO +: `APB_REG_IDX_W];
  assign guard_err = |bus.paddr[`APB_GUARD_HI:`APB_GUARD_LO];
  assign access    = psel && bus.penable;

  // Even index completes in the first ACCESS cycle, odd one a cycle later
  assign done = access && (!idx[0] || waited);

  always_comb begin
    cpl.pready  = done;
    cpl.pslverr = done && guard_err;
    cpl.prdata  = '0;
    // Bad offset or write reads back as zero
    if (done && !bus.pwrite && !guard_err) begin
      cpl.prdata = regs[idx];
    end
  end

  // Marks the wait cycle of an odd-index access
  always_ff @(posedge pclk or negedge presetn) begin
    if (!presetn) begin
      waited <= 1'b0;
    end else begin
      waited <= access && !done;
    end
  end

  always_ff @(posedge pclk or negedge presetn) begin
    if (!presetn) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (done && bus.pwrite && !guard_err) begin
      regs[idx] <= bus.pwdata;
    end
  end

endmodule

//--- verilog/apb_requester.sv
// APB3 requester: IDLE/SETUP/ACCESS FSM, completer decode and read-data selection
`timescale 1ns/100ps
`include "apb_sub_params.svh"

module apb_requester (
  input  logic                   pclk,
  input  logic                   presetn,
  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  input  apb_sub_pkg::apb_cmd_t  cmd_in,
  output apb_sub_pkg::apb_bus_t  bus,
  output logic [`APB_NUM_CPL-1:0] psel,
  input  apb_sub_pkg::apb_cpl_t  cpl [`APB_NUM_CPL],
  output logic                   rsp_valid,
  input  logic                   rsp_ready,
  output apb_sub_pkg::apb_rsp_t  rsp
);

  import apb_sub_pkg::*;

  localparam int REGION_W = `APB_REGION_HI - `APB_REGION_LO + 1;

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS
  } apb_state_e;

  apb_state_e state;

  logic [REGION_W-1:0]     region;
  logic                    mapped;
  logic [`APB_NUM_CPL-1:0] psel_dec;
  logic                    take;
  logic                    done;
  apb_cpl_t                cpl_sel;

  logic [`APB_ADDR_W-1:0]  paddr_q;
  logic                    pwrite_q;
  logic [`APB_DATA_W-1:0]  pwdata_q;
  logic                    penable_q;

  // Accept only when the response stage is empty and nothing is pending for it
  assign cmd_ready = (state == IDLE) && rsp_ready && !rsp_valid;
  assign take      = cmd_valid && cmd_ready;
  assign done      = (state == ACCESS) && cpl_sel.pready;

  // Region to one-hot select
  always_comb begin
    region   = cmd_in.addr[`APB_REGION_HI:`APB_REGION_LO];
    mapped   = 1'b0;
    psel_dec = '0;
    for (int i = 0; i < `APB_NUM_CPL; i++) begin
      if (int'(region) == i) begin
        psel_dec[i] = 1'b1;
        mapped      = 1'b1;
      end
    end
  end

  // Return path from whichever completer is selected
  always_comb begin
    cpl_sel = '0;
    for (int i = 0; i < `APB_NUM_CPL; i++) begin
      if (psel[i]) begin
        cpl_sel = cpl[i];
      end
    end
  end

  always_comb begin
    bus.paddr   = paddr_q;
    bus.pwrite  = pwrite_q;
    bus.pwdata  = pwdata_q;
    bus.penable = penable_q;
  end

  always_ff @(posedge pclk or negedge presetn) begin
    if (!presetn) begin
      state     <= IDLE;
      psel      <= '0;
      penable_q <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= 1'b0;
      case (state)
        IDLE: begin
          if (take) begin
            if (mapped) begin
              psel  <= psel_dec;
              state <= SETUP;
            end else begin
              // Unmapped, answer straight away without a bus cycle
              rsp_valid <= 1'b1;
            end
          end
        end
        SETUP: begin
          penable_q <= 1'b1;
          state     <= ACCESS;
        end
        ACCESS: begin
          if (cpl_sel.pready) begin
            psel      <= '0;
            penable_q <= 1'b0;
            rsp_valid <= 1'b1;
            state     <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Address, data and response payload
  always_ff @(posedge pclk) begin
    if (take) begin
      paddr_q  <= cmd_in.addr;
      pwrite_q <= cmd_in.write;
      pwdata_q <= cmd_in.wdata;
    end
    if (take && !mapped) begin
      rsp.write <= cmd_in.write;
      rsp.rdata <= '0;
      rsp.err   <= 1'b1;
    end else if (done) begin
      rsp.write <= pwrite_q;
      rsp.rdata <= cpl_sel.prdata;
      rsp.err   <= cpl_sel.pslverr;
    end
  end

endmodule

//--- verilog/apb_rsp_stage.sv
// Response stage: one-entry holding register and four-phase req/ack output port
`timescale 1ns/100ps
`include "apb_sub_params.svh"

module apb_rsp_stage (
  input  logic                  pclk,
  input  logic                  presetn,
  input  logic                  rsp_valid,
  output logic                  rsp_ready,
  input  apb_sub_pkg::apb_rsp_t rsp,
  output logic                  rsp_req,
  input  logic                  rsp_ack,
  output apb_sub_pkg::apb_rsp_t rsp_out
);

  typedef enum logic [1:0] {
    EMPTY,
    REQ,
    DRAIN
  } rsp_state_e;

  rsp_state_e state;

  assign rsp_ready = (state == EMPTY);
  assign rsp_req   = (state == REQ);

  always_ff @(posedge pclk or negedge presetn) begin
    if (!presetn) begin
      state <= EMPTY;
    end else begin
      case (state)
        EMPTY: begin
          if (rsp_valid) begin
            state <= REQ;
          end
        end
        // Hold req until the sink acknowledges
        REQ: begin
          if (rsp_ack) begin
            state <= DRAIN;
          end
        end
        // Sink must drop ack before the next response goes out
        DRAIN: begin
          if (!rsp_ack) begin
            state <= EMPTY;
          end
        end
        default: state <= EMPTY;
      endcase
    end
  end

  always_ff @(posedge pclk) begin
    if (rsp_valid && rsp_ready) begin
      rsp_out <= rsp;
    end
  end

endmodule

//--- verilog/apb_sub_params.svh
// Bus widths, completer count, bank depth and address-map field positions
`ifndef APB_SUB_PARAMS_SVH
`define APB_SUB_PARAMS_SVH

// Bus widths
`define APB_ADDR_W     16
`define APB_DATA_W     32

// Completers on the bus and registers per completer (2**APB_REG_IDX_W)
`define APB_NUM_CPL    2
`define APB_REG_IDX_W  4

// Address map: region selects the completer, guard must be zero
`define APB_REGION_HI  11
`define APB_REGION_LO  8
`define APB_GUARD_HI   7
`define APB_GUARD_LO   6
// Register index starts at the word offset
`define APB_IDX_LO     2

`endif

//--- verilog/apb_sub_pkg.sv
// Package with the command, response and APB bus packed structs
`include "apb_sub_params.svh"

package apb_sub_pkg;

  // Host command as captured by the command stage
  typedef struct packed {
    logic                   write;
    logic [`APB_ADDR_W-1:0] addr;
    logic [`APB_DATA_W-1:0] wdata;
  } apb_cmd_t;

  // Result of one command, mapped or not
  typedef struct packed {
    logic                   write;
    logic [`APB_DATA_W-1:0] rdata;
    logic                   err;
  } apb_rsp_t;

  // Requester to completers, psel kept apart as a one-hot vector
  typedef struct packed {
    logic [`APB_ADDR_W-1:0] paddr;
    logic                   pwrite;
    logic [`APB_DATA_W-1:0] pwdata;
    logic                   penable;
  } apb_bus_t;

  // Completer back to requester
  typedef struct packed {
    logic [`APB_DATA_W-1:0] prdata;
    logic                   pready;
    logic                   pslverr;
  } apb_cpl_t;

endpackage

//--- verilog/apb_subsys_top.sv
// Subsystem top: command stage, APB requester, completers and response stage
`timescale 1ns/100ps
`include "apb_sub_params.svh"

module apb_subsys_top (
  input  logic                  pclk,
  input  logic                  presetn,
  input  logic                  cmd_req,
  output logic                  cmd_ack,
  input  apb_sub_pkg::apb_cmd_t cmd,
  output logic                  rsp_req,
  input  logic                  rsp_ack,
  output apb_sub_pkg::apb_rsp_t rsp_out
);

  import apb_sub_pkg::*;

  // Command stage to requester
  logic     cmd_valid;
  logic     cmd_ready;
  apb_cmd_t cmd_q;

  // APB bus
  apb_bus_t                bus;
  logic [`APB_NUM_CPL-1:0] psel;
  apb_cpl_t                cpl [`APB_NUM_CPL];

  // Requester to response stage
  logic     rsp_valid;
  logic     rsp_ready;
  apb_rsp_t rsp;

  apb_cmd_stage u_cmd_stage (
    .pclk      (pclk),
    .presetn   (presetn),
    .cmd_req   (cmd_req),
    .cmd_ack   (cmd_ack),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_out   (cmd_q)
  );

  apb_requester u_requester (
    .pclk      (pclk),
    .presetn   (presetn),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_in    (cmd_q),
    .bus       (bus),
    .psel      (psel),
    .cpl       (cpl),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
  );

  // One register bank per address region
  for (genvar g = 0; g < `APB_NUM_CPL; g++) begin : g_cpl
    apb_completer_regs u_completer (
      .pclk    (pclk),
      .presetn (presetn),
      .psel    (psel[g]),
      .bus     (bus),
      .cpl     (cpl[g])
    );
  end

  apb_rsp_stage u_rsp_stage (
    .pclk      (pclk),
    .presetn   (presetn),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp),
    .rsp_req   (rsp_req),
    .rsp_ack   (rsp_ack),
    .rsp_out   (rsp_out)
  );

endmodule
